// File: common/smc_pkg.sv
// Shared types for the lite static memory controller
// Only single AHB transfers on one chip select are supported
// RETRY and SPLIT responses are not encoded since the slave never uses them
// APB register offsets assume a 5-bit byte address
package smc_pkg;

  // --------------------
  // AHB encodings
  // --------------------
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  typedef enum logic [2:0] {
    HSIZE_BYTE   = 3'b000,
    HSIZE_HALF   = 3'b001,
    HSIZE_WORD   = 3'b010,
    HSIZE_DWORD  = 3'b011,  // Everything from here up is illegal here
    HSIZE_4WORD  = 3'b100,
    HSIZE_8WORD  = 3'b101,
    HSIZE_16WORD = 3'b110,
    HSIZE_32WORD = 3'b111
  } hsize_e;

  typedef enum logic [1:0] {
    HRESP_OKAY  = 2'b00,
    HRESP_ERROR = 2'b01
  } hresp_e;

  // --------------------
  // EMI access FSM
  // --------------------
  typedef enum logic [2:0] {
    EMI_IDLE      = 3'd0,
    EMI_SETUP     = 3'd1,  // Address and n_cs out, data sampled from AHB
    EMI_STROBE    = 3'd2,  // W+1 cycles of n_rd or n_wr
    EMI_HOLD      = 3'd3,  // Last data phase cycle
    EMI_ERR_FIRST = 3'd4,
    EMI_ERR_LAST  = 3'd5
  } emi_state_e;

  // Decode to execute request
  typedef struct packed {
    logic [15:0] addr;   // Word address inside the window
    logic        write;
    logic [3:0]  be;     // Active high, lane 0 = bits 7:0
    logic        err;    // Classified as error, no strobe
  } smc_req_t;

  // Register block outputs
  typedef struct packed {
    logic [3:0] wait_states;
    logic       write_protect;
  } smc_cfg_t;

  // External memory pins
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  n_be;
    logic        n_cs;
    logic [3:0]  n_we;
    logic        n_wr;
    logic        n_rd;
    logic        n_ext_oe;
  } emi_bus_t;

  // APB map
  localparam logic [4:0] REG_CONFIG = 5'h00;
  localparam logic [4:0] REG_COUNT  = 5'h04;

  localparam smc_cfg_t CFG_RESET = '{wait_states: 4'd0, write_protect: 1'b0};

endpackage

// File: hw/smc_apb_regs.sv
// APB register block, zero wait state, no PSLVERR
// Writes land at the end of the access cycle
// prdata is combinational and valid while psel is high
// Unmapped offsets read zero and ignore writes
`timescale 1ns/1ps

module smc_apb_regs (
  input  logic              hclk,
  input  logic              arst_n,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [4:0]        paddr,
  input  logic [31:0]       pwdata,
  input  logic              xfer_done,   // One pulse per OKAY transfer
  output logic [31:0]       prdata,
  output smc_pkg::smc_cfg_t cfg
);

  import smc_pkg::*;

  logic        apb_wr;       // Access phase of a write
  logic [31:0] xfer_count;   // Completed OKAY transfers

  assign apb_wr = psel && penable && pwrite;

  // --------------------
  // Config register
  // --------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      cfg <= CFG_RESET;
    end else if (apb_wr && (paddr == REG_CONFIG)) begin
      cfg.wait_states   <= pwdata[3:0];
      cfg.write_protect <= pwdata[8];
    end
  end

  // --------------------
  // Transfer counter
  // --------------------
  // Any write clears it, the clear wins over a same-cycle completion
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      xfer_count <= '0;
    end else if (apb_wr && (paddr == REG_COUNT)) begin
      xfer_count <= '0;
    end else if (xfer_done) begin
      xfer_count <= xfer_count + 32'd1;  // Wraps silently
    end
  end

  // Read mux
  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        REG_CONFIG: begin
          prdata[3:0] = cfg.wait_states;
          prdata[8]   = cfg.write_protect;
        end
        REG_COUNT: prdata = xfer_count;
        default:   prdata = '0;        // Hole in the map
      endcase
    end
  end

endmodule

// File: hw/smc_veneer.sv
// Top level of the lite static memory controller
// APB port runs on hclk and shares arst_n with the AHB side
// Connect hready to the system ready mux, normally smc_hready itself
// EMI_ADDR_W up to 18 fits the 16-bit word address
`timescale 1ns/1ps

module smc_veneer #(
  parameter int EMI_ADDR_W = 16           // Byte address window width
) (
  input  logic                 hclk,
  input  logic                 arst_n,
  // AHB slave
  input  logic [31:0]          haddr,
  input  smc_pkg::htrans_e     htrans,
  input  logic                 hsel,
  input  logic                 hwrite,
  input  smc_pkg::hsize_e      hsize,
  input  logic [31:0]          hwdata,
  input  logic                 hready,
  output logic [31:0]          smc_hrdata,
  output logic                 smc_hready,
  output smc_pkg::hresp_e      smc_hresp,
  // EMI
  input  logic [31:0]          data_smc,  // Read data from memory
  output smc_pkg::emi_bus_t    smc_emi,
  output logic                 smc_busy,
  // APB
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [4:0]           paddr,
  input  logic [31:0]          pwdata,
  output logic [31:0]          prdata
);

  import smc_pkg::*;

  smc_cfg_t   cfg;
  smc_req_t   req;
  logic       req_valid;       // One cycle per accepted address phase
  emi_state_e emi_state;
  logic       strobe_last;     // Read sample cycle
  logic       xfer_done;

  smc_apb_regs apb_regs_i (
    .hclk      (hclk),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .xfer_done (xfer_done),
    .prdata    (prdata),
    .cfg       (cfg)
  );

  smc_ahb_decode #(.EMI_ADDR_W(EMI_ADDR_W)) ahb_decode_i (
    .hclk      (hclk),
    .arst_n    (arst_n),
    .haddr     (haddr),
    .htrans    (htrans),
    .hsel      (hsel),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .hready    (hready),
    .cfg       (cfg),
    .req_valid (req_valid),
    .req       (req)
  );

  smc_emi_execute emi_execute_i (
    .hclk        (hclk),
    .arst_n      (arst_n),
    .req_valid   (req_valid),
    .req         (req),
    .cfg         (cfg),
    .hwdata      (hwdata),
    .emi         (smc_emi),
    .state       (emi_state),
    .strobe_last (strobe_last),
    .busy        (smc_busy)
  );

  // Request stays registered in decode for the whole access
  smc_ahb_result ahb_result_i (
    .hclk        (hclk),
    .arst_n      (arst_n),
    .state       (emi_state),
    .strobe_last (strobe_last),
    .emi_write   (req.write),
    .data_smc    (data_smc),
    .hrdata      (smc_hrdata),
    .hready_out  (smc_hready),
    .hresp       (smc_hresp),
    .xfer_done   (xfer_done)
  );

endmodule

// File: smc_core/smc_ahb_decode.sv
// AHB address phase capture and transfer classification
// One transfer at a time, the next phase is only taken while hready is high
// BUSY and IDLE are ignored, SEQ is handled like NONSEQ
// Window address keeps the word index, so EMI_ADDR_W must stay below 19
`timescale 1ns/1ps

module smc_ahb_decode #(
  parameter int EMI_ADDR_W = 16
) (
  input  logic              hclk,
  input  logic              arst_n,
  input  logic [31:0]       haddr,
  input  smc_pkg::htrans_e  htrans,
  input  logic              hsel,
  input  logic              hwrite,
  input  smc_pkg::hsize_e   hsize,
  input  logic              hready,     // Muxed bus ready
  input  smc_pkg::smc_cfg_t cfg,
  output logic              req_valid,  // Registered, one cycle
  output smc_pkg::smc_req_t req
);

  import smc_pkg::*;

  logic       accept;
  logic       out_of_window;
  logic       bad_size;
  logic       misaligned;
  logic       protect_hit;
  logic [3:0] be;

  // --------------------
  // Address phase checks
  // --------------------
  assign accept = hsel && hready &&
                  ((htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ));

  assign out_of_window = |(haddr >> EMI_ADDR_W);  // Any bit above the window
  assign bad_size      = (hsize > HSIZE_WORD);
  assign protect_hit   = hwrite && cfg.write_protect;

  always_comb begin
    case (hsize)
      HSIZE_HALF: misaligned = haddr[0];
      HSIZE_WORD: misaligned = |haddr[1:0];
      default:    misaligned = 1'b0;    // Bytes always aligned
    endcase
  end

  // Little endian lanes
  always_comb begin
    case (hsize)
      HSIZE_BYTE: be = 4'b0001 << haddr[1:0];
      HSIZE_HALF: be = haddr[1] ? 4'b1100 : 4'b0011;
      HSIZE_WORD: be = 4'b1111;
      default:    be = 4'b0000;
    endcase
  end

  // --------------------
  // Request register
  // --------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= accept;
    end
  end

  // Held until the next accept, execute reads it for the whole access
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      req <= '0;
    end else if (accept) begin
      req.addr  <= 16'(haddr[EMI_ADDR_W-1:2]);
      req.write <= hwrite;
      req.be    <= be;
      req.err   <= out_of_window || bad_size || misaligned || protect_hit;
    end
  end

endmodule

// File: smc_core/smc_ahb_result.sv
// AHB data phase response
// hready is low from SETUP through the last strobe and in ERR_FIRST
// Read data is captured on the last strobe cycle and shown in HOLD
// xfer_done lags the HOLD cycle by one clock
`timescale 1ns/1ps

module smc_ahb_result (
  input  logic                hclk,
  input  logic                arst_n,
  input  smc_pkg::emi_state_e state,
  input  logic                strobe_last,
  input  logic                emi_write,   // Current access is a write
  input  logic [31:0]         data_smc,
  output logic [31:0]         hrdata,
  output logic                hready_out,
  output smc_pkg::hresp_e     hresp,
  output logic                xfer_done
);

  import smc_pkg::*;

  // --------------------
  // Response
  // --------------------
  assign hready_out = !((state == EMI_SETUP) || (state == EMI_STROBE) ||
                        (state == EMI_ERR_FIRST));

  // Two cycle ERROR, both cycles flagged
  assign hresp = ((state == EMI_ERR_FIRST) || (state == EMI_ERR_LAST)) ?
                 HRESP_ERROR : HRESP_OKAY;

  // Memory data sampled while n_rd is still low
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      hrdata <= '0;
    end else if (strobe_last && !emi_write) begin
      hrdata <= data_smc;
    end
  end

  // One pulse per OKAY completion
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      xfer_done <= 1'b0;
    end else begin
      xfer_done <= (state == EMI_HOLD);
    end
  end

endmodule

// File: smc_core/smc_emi_execute.sv
// EMI access sequencer
// The cycle with req_valid high is already SETUP or ERR_FIRST
// n_cs, n_be and n_ext_oe follow the state, the strobes are flops
// Wait states are sampled once per access, in SETUP
// Error requests never touch the external bus
`timescale 1ns/1ps

module smc_emi_execute (
  input  logic                hclk,
  input  logic                arst_n,
  input  logic                req_valid,
  input  smc_pkg::smc_req_t   req,
  input  smc_pkg::smc_cfg_t   cfg,
  input  logic [31:0]         hwdata,      // AHB data phase, valid in SETUP
  output smc_pkg::emi_bus_t   emi,
  output smc_pkg::emi_state_e state,
  output logic                strobe_last, // Final strobe cycle
  output logic                busy
);

  import smc_pkg::*;

  emi_state_e  state_q;
  emi_state_e  state_d;
  logic [3:0]  wait_cnt;     // Strobe cycles left after this one
  logic        strobe_next;  // Next cycle is a strobe cycle
  logic        active;       // SETUP, STROBE or HOLD
  logic        n_rd_q;
  logic        n_wr_q;
  logic [3:0]  n_we_q;
  logic [31:0] wdata_q;

  // New request overrides the idle register for its first cycle
  always_comb begin
    if (req_valid) begin
      state = req.err ? EMI_ERR_FIRST : EMI_SETUP;
    end else begin
      state = state_q;
    end
  end

  // --------------------
  // Next state
  // --------------------
  always_comb begin
    state_d     = state;
    strobe_next = 1'b0;
    case (state)
      EMI_SETUP: begin
        state_d     = EMI_STROBE;
        strobe_next = 1'b1;
      end
      EMI_STROBE: begin
        if (wait_cnt == 4'd0) begin
          state_d = EMI_HOLD;
        end else begin
          strobe_next = 1'b1;          // Stay in STROBE
        end
      end
      EMI_HOLD:      state_d = EMI_IDLE;
      EMI_ERR_FIRST: state_d = EMI_ERR_LAST;
      EMI_ERR_LAST:  state_d = EMI_IDLE;
      default:       state_d = EMI_IDLE;
    endcase
  end

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      state_q  <= EMI_IDLE;
      wait_cnt <= 4'd0;
    end else begin
      state_q <= state_d;
      if (state == EMI_SETUP) begin
        wait_cnt <= cfg.wait_states;      // STROBE then lasts W+1 cycles
      end else if ((state == EMI_STROBE) && (wait_cnt != 4'd0)) begin
        wait_cnt <= wait_cnt - 4'd1;
      end
    end
  end

  // --------------------
  // Strobe flops
  // --------------------
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      n_rd_q <= 1'b1;
      n_wr_q <= 1'b1;
      n_we_q <= 4'hf;
    end else begin
      n_rd_q <= !(strobe_next && !req.write);
      n_wr_q <= !(strobe_next && req.write);
      n_we_q <= (strobe_next && req.write) ? ~req.be : 4'hf;
    end
  end

  // Write data from the AHB data phase
  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      wdata_q <= '0;
    end else if (state == EMI_SETUP) begin
      wdata_q <= hwdata;
    end
  end

  // --------------------
  // Outputs
  // --------------------
  assign active      = (state == EMI_SETUP) || (state == EMI_STROBE) ||
                       (state == EMI_HOLD);
  assign strobe_last = (state == EMI_STROBE) && (wait_cnt == 4'd0);
  assign busy        = active;

  assign emi.addr     = {14'd0, req.addr, 2'b00};   // Byte address, word aligned
  assign emi.data     = wdata_q;
  assign emi.n_be     = active ? ~req.be : 4'hf;
  assign emi.n_cs     = !active;
  assign emi.n_we     = n_we_q;
  assign emi.n_wr     = n_wr_q;
  assign emi.n_rd     = n_rd_q;
  assign emi.n_ext_oe = !(active && req.write);     // Drive data pins on writes

endmodule

// File: smc_lite.f
+incdir+verification
common/smc_pkg.sv
smc_core/smc_ahb_decode.sv
smc_core/smc_emi_execute.sv
smc_core/smc_ahb_result.sv
hw/smc_apb_regs.sv
hw/smc_veneer.sv
verification/smc_sram_model.sv
verification/smc_tb.sv

// File: verification/smc_sram_model.sv
// Asynchronous SRAM model on the EMI pins, 64 KiB in byte lanes
// Only the low 16 bits of the EMI address are decoded
// Writes land on each rising clock edge while n_cs and n_wr are low
// Read data is combinational while n_rd is low, zero otherwise
`timescale 1ns/1ps

module smc_sram_model (
  input  logic              clk,
  input  smc_pkg::emi_bus_t emi,
  output logic [31:0]       rdata
);

  logic [7:0]  mem [0:65535];
  logic [15:0] base;            // Word aligned byte address

  assign base = {emi.addr[15:2], 2'b00};

  // Power-up contents, both address bytes feed the pattern
  initial begin
    for (int i = 0; i < 65536; i++) begin
      mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3c;
    end
  end

  always @(posedge clk) begin
    if (!emi.n_cs && !emi.n_wr) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (!emi.n_we[lane]) begin
          mem[base + 16'(lane)] <= emi.data[lane*8 +: 8];  // Lane 0 = bits 7:0
        end
      end
    end
  end

  assign rdata = (!emi.n_cs && !emi.n_rd) ?
                 {mem[base + 16'd3], mem[base + 16'd2], mem[base + 16'd1], mem[base]} :
                 32'h0;

endmodule

// File: verification/smc_tb_tasks.svh
// Bus, compare and shadow memory tasks for smc_tb
// Every task is entered and left just after a falling hclk edge
// Needs the smc_tb signals, counters and cur_wait in scope
`ifndef SMC_TB_TASKS_SVH
`define SMC_TB_TASKS_SVH

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_data(input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input hresp_e got, input hresp_e exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s hresp %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_cycles(input int got, input int exp, input string what);
    if (got != exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s took %0d cycles, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_lanes(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s n_be %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timed out at %0t while waiting for %s", $time, what);
  endtask

  // --------------------
  // Shadow memory
  // --------------------
  function automatic logic [7:0] fill_byte(input int addr);
    return 8'(addr) ^ 8'(addr >> 8) ^ 8'h3c;  // Same power-up image as the SRAM
  endfunction

  task automatic shadow_fill();
    for (int i = 0; i < 65536; i++) begin
      shadow[i] = fill_byte(i);
    end
  endtask

  // Byte at address a rides on lane a mod 4
  task automatic shadow_store(input logic [31:0] addr, input hsize_e size,
                              input logic [31:0] data);
    int lane;
    for (int k = 0; k < (1 << int'(size)); k++) begin
      lane = int'(addr[1:0]) + k;
      shadow[int'(addr[15:0]) + k] = data[lane*8 +: 8];
    end
  endtask

  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    int base;
    base = int'({addr[15:2], 2'b00});
    return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
  endfunction

  // Lanes touched by a transfer, same rule as the shadow store
  function automatic logic [3:0] lane_mask(input logic [31:0] addr, input hsize_e size);
    logic [3:0] mask;
    mask = 4'h0;
    for (int k = 0; k < (1 << int'(size)); k++) begin
      mask[int'(addr[1:0]) + k] = 1'b1;
    end
    return mask;
  endfunction

  // --------------------
  // AHB
  // --------------------
  // One single transfer, cycles counted from the accepting edge
  task automatic ahb_access(input logic write, input logic [31:0] addr, input hsize_e size,
                            input logic [31:0] wdata, input hresp_e exp,
                            output logic [31:0] rdata);
    int         waited;
    int         cycles;
    int         strobes;
    int         busy_cyc;
    int         oe_cyc;
    int         exp_len;
    logic       ok;
    logic [3:0] n_be;
    string      what;
    ok      = (exp == HRESP_OKAY);
    exp_len = ok ? cur_wait + 3 : 2;
    what    = $sformatf("%s 0x%08h", write ? "write" : "read", addr);
    waited  = 0;
    while (!smc_hready && (waited < TIMEOUT)) begin
      @(negedge hclk);
      waited++;
    end
    if (!smc_hready) begin
      report_timeout("smc_hready before an address phase");
    end
    hsel   = 1'b1;
    htrans = HTRANS_NONSEQ;
    haddr  = addr;
    hwrite = write;
    hsize  = size;
    @(negedge hclk);                    // First data phase cycle
    hsel   = 1'b0;
    htrans = HTRANS_IDLE;
    hwdata = wdata;
    check_resp(smc_hresp, exp, {what, " first cycle"});
    n_be     = smc_emi.n_be;            // Lanes valid from SETUP on
    cycles   = 1;
    strobes  = 0;
    busy_cyc = smc_busy ? 1 : 0;
    oe_cyc   = !smc_emi.n_ext_oe ? 1 : 0;
    while (!smc_hready && (cycles < TIMEOUT)) begin
      @(negedge hclk);
      cycles++;
      if (!smc_emi.n_rd || !smc_emi.n_wr) begin
        strobes++;
      end
      if (smc_busy) begin
        busy_cyc++;
      end
      if (!smc_emi.n_ext_oe) begin
        oe_cyc++;
      end
    end
    if (!smc_hready) begin
      report_timeout("smc_hready to end a data phase");
    end
    check_resp(smc_hresp, exp, {what, " last cycle"});
    check_cycles(cycles, exp_len, what);
    check_cycles(strobes, ok ? cur_wait + 1 : 0, {what, " strobe"});
    check_cycles(busy_cyc, ok ? exp_len : 0, {what, " smc_busy"});
    check_cycles(oe_cyc, (ok && write) ? exp_len : 0, {what, " n_ext_oe low"});
    check_lanes(n_be, ok ? ~lane_mask(addr, size) : 4'hf, what);
    rdata = smc_hrdata;                 // Held through HOLD
  endtask

  task automatic ahb_write(input logic [31:0] addr, input hsize_e size,
                           input logic [31:0] data, input hresp_e exp);
    logic [31:0] rd;
    ahb_access(1'b1, addr, size, data, exp, rd);
    if (exp == HRESP_OKAY) begin
      shadow_store(addr, size, data);
      okay_xfers++;
    end
  endtask

  task automatic ahb_read(input logic [31:0] addr, input hsize_e size, input hresp_e exp);
    logic [31:0] rd;
    ahb_access(1'b0, addr, size, 32'h0, exp, rd);
    if (exp == HRESP_OKAY) begin
      check_data(rd, shadow_word(addr), $sformatf("read 0x%08h", addr));
      okay_xfers++;
    end
  endtask

  // --------------------
  // APB, zero wait state
  // --------------------
  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge hclk);
    penable = 1'b1;
    @(negedge hclk);                    // Write taken on the edge before
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge hclk);
    penable = 1'b1;
    data    = prdata;                   // Settled since setup, penable not used
    @(negedge hclk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge hclk);
  endtask

`endif

// File: verification/smc_tb.sv
// Directed testbench for the lite static memory controller
// hready loops back from smc_hready, APB shares hclk
// Shadow memory starts from the same image as the SRAM model
`timescale 1ns/1ps

module smc_tb;

  import smc_pkg::*;

  localparam int TIMEOUT = 64;          // Cycles per wait loop

  logic        hclk;
  logic        arst_n;
  logic [31:0] haddr;
  htrans_e     htrans;
  logic        hsel;
  logic        hwrite;
  hsize_e      hsize;
  logic [31:0] hwdata;
  logic [31:0] data_smc;                // From the SRAM model
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [4:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic [31:0] smc_hrdata;
  logic        smc_hready;
  hresp_e      smc_hresp;
  emi_bus_t    smc_emi;
  logic        smc_busy;

  int         errors;
  int         timeouts;
  int         okay_xfers;               // Expected REG_COUNT
  int         cur_wait;                 // Wait states last written
  logic [7:0] shadow [0:65535];

  always #2 hclk = ~hclk;

  smc_veneer #(.EMI_ADDR_W(16)) dut_i (
    .hclk(hclk), .arst_n(arst_n), .haddr(haddr), .htrans(htrans), .hsel(hsel),
    .hwrite(hwrite), .hsize(hsize), .hwdata(hwdata), .hready(smc_hready),
    .smc_hrdata(smc_hrdata), .smc_hready(smc_hready), .smc_hresp(smc_hresp),
    .data_smc(data_smc), .smc_emi(smc_emi), .smc_busy(smc_busy),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata)
  );

  smc_sram_model sram_i (.clk(hclk), .emi(smc_emi), .rdata(data_smc));

  task automatic end_run();
    $display("Closing summary: %0d check errors, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  `include "smc_tb_tasks.svh"

  // --------------------
  // Directed tests
  // --------------------
  task automatic test_reset_values();
    logic [31:0] rd;
    check_flag(smc_hready, 1'b1, "smc_hready after reset");
    check_resp(smc_hresp, HRESP_OKAY, "smc_hresp after reset");
    check_flag(smc_busy, 1'b0, "smc_busy after reset");
    check_flag(smc_emi.n_cs, 1'b1, "n_cs after reset");
    check_flag(smc_emi.n_rd, 1'b1, "n_rd after reset");
    check_flag(smc_emi.n_wr, 1'b1, "n_wr after reset");
    check_flag(&smc_emi.n_we, 1'b1, "n_we after reset");
    check_flag(smc_emi.n_ext_oe, 1'b1, "n_ext_oe after reset");
    apb_read(REG_CONFIG, rd);
    check_data(rd, 32'h0000_0000, "REG_CONFIG after reset");  // No waits, no protect
  endtask

  // Random words written, then read back
  task automatic test_word_rw(input int n);
    logic [31:0] addrs [16];
    for (int i = 0; i < n; i++) begin
      addrs[i] = {16'h0, 16'($urandom) & 16'hfffc};
      ahb_write(addrs[i], HSIZE_WORD, $urandom, HRESP_OKAY);
    end
    for (int i = 0; i < n; i++) begin
      ahb_read(addrs[i], HSIZE_WORD, HRESP_OKAY);
    end
  endtask

  task automatic test_lanes(input logic [31:0] base);
    ahb_write(base, HSIZE_WORD, $urandom, HRESP_OKAY);
    for (int off = 0; off < 4; off++) begin
      ahb_write(base + 32'(off), HSIZE_BYTE, $urandom, HRESP_OKAY);
      ahb_read(base, HSIZE_WORD, HRESP_OKAY);
    end
    for (int off = 0; off < 4; off += 2) begin
      ahb_write(base + 32'(off), HSIZE_HALF, $urandom, HRESP_OKAY);
      ahb_read(base, HSIZE_WORD, HRESP_OKAY);
    end
    ahb_read(base + 32'd4, HSIZE_WORD, HRESP_OKAY);   // Neighbour untouched
  endtask

  task automatic test_wait_states();
    logic [31:0] rd;
    apb_write(REG_CONFIG, 32'd5);
    cur_wait = 5;
    apb_read(REG_CONFIG, rd);
    check_data(rd, 32'd5, "REG_CONFIG wait states");
    test_word_rw(4);
  endtask

  // All four error kinds, memory checked through a legal read
  task automatic test_errors(input logic [31:0] base);
    ahb_write(base, HSIZE_WORD, $urandom, HRESP_OKAY);
    ahb_write(base | 32'h0001_0000, HSIZE_WORD, $urandom, HRESP_ERROR);
    ahb_read(base | 32'h0001_0000, HSIZE_WORD, HRESP_ERROR);
    ahb_write(base + 32'd1, HSIZE_HALF, $urandom, HRESP_ERROR);
    ahb_write(base, HSIZE_DWORD, $urandom, HRESP_ERROR);
    ahb_read(base, HSIZE_WORD, HRESP_OKAY);
    apb_write(REG_CONFIG, 32'h100 | 32'(cur_wait));    // Protect on
    ahb_write(base, HSIZE_WORD, $urandom, HRESP_ERROR);
    ahb_read(base, HSIZE_WORD, HRESP_OKAY);            // Reads still allowed
    apb_write(REG_CONFIG, 32'(cur_wait));
  endtask

  task automatic test_count();
    logic [31:0] rd;
    idle_cycles(2);                     // Let the last completion land
    apb_read(REG_COUNT, rd);
    check_data(rd, 32'(okay_xfers), "REG_COUNT");
    apb_write(REG_COUNT, 32'hffff_ffff);
    apb_read(REG_COUNT, rd);
    check_data(rd, 32'd0, "REG_COUNT after clear");
    okay_xfers = 0;
    ahb_read(32'h0000_0040, HSIZE_WORD, HRESP_OKAY);
    idle_cycles(2);
    apb_read(REG_COUNT, rd);
    check_data(rd, 32'(okay_xfers), "REG_COUNT after clear and one read");
  endtask

  initial begin
    void'($urandom(84));
    errors     = 0;
    timeouts   = 0;
    okay_xfers = 0;
    cur_wait   = 0;
    hclk       = 1'b0;
    arst_n     = 1'b0;
    haddr      = '0;
    htrans     = HTRANS_IDLE;
    hsel       = 1'b0;
    hwrite     = 1'b0;
    hsize      = HSIZE_WORD;
    hwdata     = '0;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    shadow_fill();
    repeat (10) @(posedge hclk);
    @(negedge hclk);
    arst_n = 1'b1;
    test_reset_values();
    test_word_rw(8);
    test_lanes(32'h0000_0100);
    test_wait_states();
    test_errors(32'h0000_0200);
    test_count();
    end_run();
  end

endmodule
